// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f decode_stage.f \
		--top-module decode_stage_tb -o Vdecode_stage_tb
	out="$$(./obj_dir/Vdecode_stage_tb)"; echo "$$out"; \
		echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

// File: decode_stage.f
logic/decode_pkg.sv
logic/inst_decoder.sv
logic/operand_forward.sv
logic/branch_unit.sv
logic/gpr_file.sv
logic/id_ex_reg.sv
logic/decode_stage.sv
sim/tb_clock.sv
sim/decode_stage_tb.sv

// File: logic/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit import decode_pkg::*; (
    input  logic              rst_n,
    input  logic [DATA_W-1:0] pc,
    input  inst_u             inst,
    input  br_kind_t          br_kind,
    input  logic              link,
    input  logic [DATA_W-1:0] num1,
    input  logic [DATA_W-1:0] num2,
    output logic              branch_flag,
    output logic [DATA_W-1:0] branch_target,
    output logic              next_in_delayslot,
    output logic [DATA_W-1:0] link_address
);

    logic [DATA_W-1:0] pc_plus4;
    logic [DATA_W-1:0] pc_plus8;
    logic [DATA_W-1:0] br_offset;
    logic              equal;

    assign pc_plus4  = pc + 32'd4;                           // delay slot
    assign pc_plus8  = pc + 32'd8;                           // return point
    assign br_offset = {{14{inst.i_fmt.imm16[15]}}, inst.i_fmt.imm16, 2'b00};
    assign equal     = (num1 == num2);

    always_comb begin
        branch_flag   = 1'b0;
        branch_target = '0;
        if (rst_n) begin
            case (br_kind)
                BR_JUMP_IMM: begin
                    branch_flag   = 1'b1;
                    branch_target = {pc_plus4[31:28], inst.j_fmt.target26, 2'b00};
                end
                BR_JUMP_REG: begin
                    branch_flag   = 1'b1;
                    branch_target = num1;                    // rs
                end
                BR_BEQ: begin
                    if (equal) begin
                        branch_flag   = 1'b1;
                        branch_target = pc_plus4 + br_offset;
                    end
                end
                BR_BNE: begin
                    if (!equal) begin
                        branch_flag   = 1'b1;
                        branch_target = pc_plus4 + br_offset;
                    end
                end
                default: ;
            endcase
        end
    end

    // the slot after a taken transfer always executes
    assign next_in_delayslot = branch_flag;
    assign link_address      = link ? pc_plus8 : '0;

endmodule

`default_nettype wire

// File: logic/decode_pkg.sv
`default_nettype none

package decode_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;  // $ra, written by jal

    // primary opcodes
    localparam logic [5:0] OPC_SPECIAL = 6'b000000;
    localparam logic [5:0] OPC_J       = 6'b000010;
    localparam logic [5:0] OPC_JAL     = 6'b000011;
    localparam logic [5:0] OPC_BEQ     = 6'b000100;
    localparam logic [5:0] OPC_BNE     = 6'b000101;
    localparam logic [5:0] OPC_ADDI    = 6'b001000;
    localparam logic [5:0] OPC_ADDIU   = 6'b001001;
    localparam logic [5:0] OPC_SLTI    = 6'b001010;
    localparam logic [5:0] OPC_SLTIU   = 6'b001011;
    localparam logic [5:0] OPC_ANDI    = 6'b001100;
    localparam logic [5:0] OPC_ORI     = 6'b001101;
    localparam logic [5:0] OPC_XORI    = 6'b001110;
    localparam logic [5:0] OPC_LUI     = 6'b001111;
    localparam logic [5:0] OPC_LW      = 6'b100011;
    localparam logic [5:0] OPC_SW      = 6'b101011;

    // funct field under SPECIAL
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_JR   = 6'b001000;
    localparam logic [5:0] FN_JALR = 6'b001001;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    typedef enum logic [7:0] {
        OP_NOP  = 8'h00, OP_SRL   = 8'h02, OP_SRA  = 8'h03, OP_JR  = 8'h08,
        OP_JALR = 8'h09, OP_ADD   = 8'h20, OP_ADDU = 8'h21, OP_SUB = 8'h22,
        OP_SUBU = 8'h23, OP_AND   = 8'h24, OP_OR   = 8'h25, OP_XOR = 8'h26,
        OP_NOR  = 8'h27, OP_SLT   = 8'h2a, OP_SLTU = 8'h2b, OP_J   = 8'h4f,
        OP_JAL  = 8'h50, OP_BEQ   = 8'h51, OP_BNE  = 8'h52, OP_ADDI = 8'h55,
        OP_ADDIU = 8'h56, OP_SLL  = 8'h7c, OP_LW   = 8'he3, OP_SW  = 8'heb
    } op_t;

    typedef enum logic [2:0] {
        SEL_NOP         = 3'd0,
        SEL_LOGIC       = 3'd1,
        SEL_SHIFT       = 3'd2,
        SEL_ARITH       = 3'd4,
        SEL_JUMP_BRANCH = 3'd6,
        SEL_LOAD_STORE  = 3'd7
    } sel_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_JUMP_IMM, BR_JUMP_REG, BR_BEQ, BR_BNE
    } br_kind_t;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target26;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    typedef struct packed {
        logic                  rd1_en;
        logic                  rd2_en;
        logic [REG_ADDR_W-1:0] rd1_addr;
        logic [REG_ADDR_W-1:0] rd2_addr;
        logic                  wd;
        logic [REG_ADDR_W-1:0] dest;
        op_t                   op;
        sel_t                  sel;
        logic [DATA_W-1:0]     imm;
        br_kind_t              br_kind;
        logic                  link;
    } dec_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]     data;
    } fwd_t;

    typedef struct packed {
        op_t                   op;
        sel_t                  sel;
        logic [DATA_W-1:0]     num1;
        logic [DATA_W-1:0]     num2;
        logic                  wd;
        logic [REG_ADDR_W-1:0] dest;
        logic [DATA_W-1:0]     link_address;
        logic                  in_delayslot;
    } id_ex_t;

endpackage

`default_nettype wire

// File: logic/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import decode_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [DATA_W-1:0] pc,
    input  inst_u             inst,
    input  logic              in_delayslot,
    input  logic [DATA_W-1:0] ex_result,
    input  fwd_t              mem_fwd,
    input  fwd_t              wb,
    output logic              stall,
    output logic              branch_flag,
    output logic [DATA_W-1:0] branch_target,
    output logic              next_in_delayslot,
    output id_ex_t            ex
);

    dec_t              dec;
    logic [DATA_W-1:0] rd1_data;
    logic [DATA_W-1:0] rd2_data;
    logic [DATA_W-1:0] num1;
    logic [DATA_W-1:0] num2;
    logic [DATA_W-1:0] link_address;
    logic              hazard1;
    logic              hazard2;
    logic              ex_is_load;

    assign ex_is_load = (ex.op == OP_LW);        // execute tap from our own id/ex
    assign stall      = hazard1 | hazard2;

    inst_decoder i_dec (.rst_n(rst_n), .inst(inst), .dec(dec));

    gpr_file i_gpr (
        .clk(clk), .rst_n(rst_n),
        .rd1_addr(dec.rd1_addr), .rd2_addr(dec.rd2_addr),
        .rd1_data(rd1_data), .rd2_data(rd2_data), .wb(wb)
    );

    operand_forward i_fwd1 (
        .rd_en(dec.rd1_en), .rd_addr(dec.rd1_addr), .rf_data(rd1_data), .imm(dec.imm),
        .ex_wd(ex.wd), .ex_dest(ex.dest), .ex_is_load(ex_is_load), .ex_result(ex_result),
        .mem_fwd(mem_fwd), .num(num1), .load_hazard(hazard1)
    );

    operand_forward i_fwd2 (
        .rd_en(dec.rd2_en), .rd_addr(dec.rd2_addr), .rf_data(rd2_data), .imm(dec.imm),
        .ex_wd(ex.wd), .ex_dest(ex.dest), .ex_is_load(ex_is_load), .ex_result(ex_result),
        .mem_fwd(mem_fwd), .num(num2), .load_hazard(hazard2)
    );

    branch_unit i_br (
        .rst_n(rst_n), .pc(pc), .inst(inst), .br_kind(dec.br_kind), .link(dec.link),
        .num1(num1), .num2(num2), .branch_flag(branch_flag), .branch_target(branch_target),
        .next_in_delayslot(next_in_delayslot), .link_address(link_address)
    );

    id_ex_reg i_id_ex (
        .clk(clk), .rst_n(rst_n), .bubble(stall), .dec(dec),
        .num1(num1), .num2(num2), .link_address(link_address),
        .in_delayslot(in_delayslot), .ex(ex)
    );

endmodule

`default_nettype wire

// File: logic/gpr_file.sv
`timescale 1ns/1ps
`default_nettype none

module gpr_file import decode_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [REG_ADDR_W-1:0] rd1_addr,
    input  logic [REG_ADDR_W-1:0] rd2_addr,
    output logic [DATA_W-1:0]     rd1_data,
    output logic [DATA_W-1:0]     rd2_data,
    input  fwd_t                  wb
);

    logic [DATA_W-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && (wb.addr != '0)) begin    // $zero stays 0
            regs[wb.addr] <= wb.data;
        end
    end

    // no write-through so a same-cycle read sees the old value
    assign rd1_data = regs[rd1_addr];
    assign rd2_data = regs[rd2_addr];

    // $zero reads zero on both ports whatever the write port did before
    assert property (@(posedge clk) disable iff (!rst_n)
        ((rd1_addr != '0) || (rd1_data == '0)) && ((rd2_addr != '0) || (rd2_data == '0)));

endmodule

`default_nettype wire

// File: logic/id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg import decode_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              bubble,
    input  dec_t              dec,
    input  logic [DATA_W-1:0] num1,
    input  logic [DATA_W-1:0] num2,
    input  logic [DATA_W-1:0] link_address,
    input  logic              in_delayslot,
    output id_ex_t            ex
);

    always_ff @(posedge clk) begin
        ex.num1         <= num1;                 // operands follow every cycle
        ex.num2         <= num2;
        ex.link_address <= link_address;
        if (!rst_n || bubble) begin
            ex.op           <= OP_NOP;
            ex.sel          <= SEL_NOP;
            ex.wd           <= 1'b0;
            ex.dest         <= '0;
            ex.in_delayslot <= 1'b0;
        end else begin
            ex.op           <= dec.op;
            ex.sel          <= dec.sel;
            ex.wd           <= dec.wd;
            ex.dest         <= dec.dest;
            ex.in_delayslot <= in_delayslot;
        end
    end

    // a slot that writes back always carries a decoded op
    assert property (@(posedge clk) disable iff (!rst_n) ex.wd |-> (ex.sel != SEL_NOP));

endmodule

`default_nettype wire

// File: logic/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import decode_pkg::*; (
    input  logic  rst_n,
    input  inst_u inst,
    output dec_t  dec
);

    logic [DATA_W-1:0] imm_zx;
    logic [DATA_W-1:0] imm_sx;
    logic [DATA_W-1:0] imm_hi;
    logic [DATA_W-1:0] imm_sa;
    logic              shamt_zero;
    logic              rs_zero;

    assign imm_zx     = {16'h0000, inst.i_fmt.imm16};               // logic ops
    assign imm_sx     = {{16{inst.i_fmt.imm16[15]}}, inst.i_fmt.imm16};
    assign imm_hi     = {inst.i_fmt.imm16, 16'h0000};               // lui
    assign imm_sa     = {27'd0, inst.r_fmt.shamt};
    assign shamt_zero = (inst.r_fmt.shamt == '0);
    assign rs_zero    = (inst.r_fmt.rs == '0);

    // rs op rt, result to rd
    function automatic dec_t reg_op(dec_t d, op_t op, sel_t sel);
        d.rd1_en = 1'b1;
        d.rd2_en = 1'b1;
        d.wd     = 1'b1;
        d.op     = op;
        d.sel    = sel;
        return d;
    endfunction

    // rs op imm, result to rt
    function automatic dec_t imm_op(dec_t d, op_t op, sel_t sel, logic [DATA_W-1:0] imm);
        d.rd1_en = 1'b1;
        d.wd     = 1'b1;
        d.dest   = d.rd2_addr;
        d.op     = op;
        d.sel    = sel;
        d.imm    = imm;
        return d;
    endfunction

    // fixed shift amount comes in as num1
    function automatic dec_t sa_op(dec_t d, op_t op, logic [DATA_W-1:0] imm);
        d.rd2_en = 1'b1;
        d.wd     = 1'b1;
        d.op     = op;
        d.sel    = SEL_SHIFT;
        d.imm    = imm;
        return d;
    endfunction

    always_comb begin
        dec = '0;                                    // nop unless decoded below
        if (rst_n) begin
            dec.rd1_addr = inst.r_fmt.rs;
            dec.rd2_addr = inst.r_fmt.rt;
            dec.dest     = inst.r_fmt.rd;
            case (inst.r_fmt.opcode)
                OPC_SPECIAL: begin
                    if (shamt_zero) begin
                        case (inst.r_fmt.funct)
                            FN_AND:  dec = reg_op(dec, OP_AND, SEL_LOGIC);
                            FN_OR:   dec = reg_op(dec, OP_OR, SEL_LOGIC);
                            FN_XOR:  dec = reg_op(dec, OP_XOR, SEL_LOGIC);
                            FN_NOR:  dec = reg_op(dec, OP_NOR, SEL_LOGIC);
                            FN_SLLV: dec = reg_op(dec, OP_SLL, SEL_SHIFT);
                            FN_SRLV: dec = reg_op(dec, OP_SRL, SEL_SHIFT);
                            FN_SRAV: dec = reg_op(dec, OP_SRA, SEL_SHIFT);
                            FN_ADD:  dec = reg_op(dec, OP_ADD, SEL_ARITH);
                            FN_ADDU: dec = reg_op(dec, OP_ADDU, SEL_ARITH);
                            FN_SUB:  dec = reg_op(dec, OP_SUB, SEL_ARITH);
                            FN_SUBU: dec = reg_op(dec, OP_SUBU, SEL_ARITH);
                            FN_SLT:  dec = reg_op(dec, OP_SLT, SEL_ARITH);
                            FN_SLTU: dec = reg_op(dec, OP_SLTU, SEL_ARITH);
                            FN_JR: begin
                                dec.rd1_en  = 1'b1;      // target in rs
                                dec.op      = OP_JR;
                                dec.sel     = SEL_JUMP_BRANCH;
                                dec.br_kind = BR_JUMP_REG;
                            end
                            FN_JALR: begin
                                dec.rd1_en  = 1'b1;
                                dec.wd      = 1'b1;      // link into rd
                                dec.op      = OP_JALR;
                                dec.sel     = SEL_JUMP_BRANCH;
                                dec.br_kind = BR_JUMP_REG;
                                dec.link    = 1'b1;
                            end
                            default: ;
                        endcase
                    end
                    if (rs_zero) begin
                        case (inst.r_fmt.funct)
                            FN_SLL:  dec = sa_op(dec, OP_SLL, imm_sa);
                            FN_SRL:  dec = sa_op(dec, OP_SRL, imm_sa);
                            FN_SRA:  dec = sa_op(dec, OP_SRA, imm_sa);
                            default: ;
                        endcase
                    end
                end
                OPC_ANDI:  dec = imm_op(dec, OP_AND, SEL_LOGIC, imm_zx);
                OPC_ORI:   dec = imm_op(dec, OP_OR, SEL_LOGIC, imm_zx);
                OPC_XORI:  dec = imm_op(dec, OP_XOR, SEL_LOGIC, imm_zx);
                OPC_LUI:   dec = imm_op(dec, OP_OR, SEL_LOGIC, imm_hi);  // $0 | imm<<16
                OPC_ADDI:  dec = imm_op(dec, OP_ADDI, SEL_ARITH, imm_sx);
                OPC_ADDIU: dec = imm_op(dec, OP_ADDIU, SEL_ARITH, imm_sx);
                OPC_SLTI:  dec = imm_op(dec, OP_SLT, SEL_ARITH, imm_sx);
                OPC_SLTIU: dec = imm_op(dec, OP_SLTU, SEL_ARITH, imm_sx);
                OPC_LW:    dec = imm_op(dec, OP_LW, SEL_LOAD_STORE, imm_sx);  // offset as num2
                OPC_SW: begin
                    dec     = reg_op(dec, OP_SW, SEL_LOAD_STORE);  // base and store data
                    dec.wd  = 1'b0;
                    dec.imm = imm_sx;
                end
                OPC_J: begin
                    dec.op      = OP_J;
                    dec.sel     = SEL_JUMP_BRANCH;
                    dec.br_kind = BR_JUMP_IMM;
                end
                OPC_JAL: begin
                    dec.wd      = 1'b1;
                    dec.dest    = LINK_REG;
                    dec.op      = OP_JAL;
                    dec.sel     = SEL_JUMP_BRANCH;
                    dec.br_kind = BR_JUMP_IMM;
                    dec.link    = 1'b1;
                end
                OPC_BEQ, OPC_BNE: begin
                    dec.rd1_en  = 1'b1;
                    dec.rd2_en  = 1'b1;
                    dec.sel     = SEL_JUMP_BRANCH;
                    dec.op      = (inst.r_fmt.opcode == OPC_BEQ) ? OP_BEQ : OP_BNE;
                    dec.br_kind = (inst.r_fmt.opcode == OPC_BEQ) ? BR_BEQ : BR_BNE;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward import decode_pkg::*; (
    input  logic                  rd_en,
    input  logic [REG_ADDR_W-1:0] rd_addr,
    input  logic [DATA_W-1:0]     rf_data,
    input  logic [DATA_W-1:0]     imm,
    input  logic                  ex_wd,
    input  logic [REG_ADDR_W-1:0] ex_dest,
    input  logic                  ex_is_load,
    input  logic [DATA_W-1:0]     ex_result,
    input  fwd_t                  mem_fwd,
    output logic [DATA_W-1:0]     num,
    output logic                  load_hazard
);

    logic ex_hit;
    logic mem_hit;

    assign ex_hit  = rd_en && (rd_addr == ex_dest);
    assign mem_hit = rd_en && mem_fwd.we && (rd_addr == mem_fwd.addr);

    // load data not ready until mem, so wait a cycle
    assign load_hazard = ex_hit && ex_is_load;

    always_comb begin
        if (ex_hit && ex_wd) begin
            num = ex_result;                     // younger writer wins
        end else if (mem_hit) begin
            num = mem_fwd.data;
        end else if (rd_en) begin
            num = rf_data;
        end else begin
            num = imm;
        end
    end

endmodule

`default_nettype wire

// File: sim/decode_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb import decode_pkg::*; ();

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        ds;
        logic [31:0] ex_result;
        fwd_t        mem;
        fwd_t        wb;
        logic        n1r;                        // num1 from rs, else imm
        logic        n2r;                        // num2 from rt, else imm
        logic [31:0] imm;
        op_t         op;
        sel_t        sel;
        logic        wd;
        logic [4:0]  dest;
        logic [2:0]  br;                         // 1 jimm, 2 jreg, 3 beq, 4 bne
        logic        link;
        logic        stall;
    } row_t;

    localparam logic [31:0] IDLE = 32'hfc00_0000;  // undecoded opcode

    logic              clk;
    logic              rst_n;
    logic [31:0]       pc;
    inst_u             inst;
    logic              in_delayslot;
    logic [31:0]       ex_result;
    fwd_t              mem_fwd;
    fwd_t              wb;
    logic              stall;
    logic              branch_flag;
    logic [31:0]       branch_target;
    logic              next_in_delayslot;
    id_ex_t            ex;
    row_t              rows[$];
    logic [31:0]       shadow[32];
    logic [31:0]       lfsr = 32'd41;
    id_ex_t            pex;                      // predicted ex of the previous row
    logic              pnums;
    int                cycles = 0;
    int                limit = 36;

    tb_clock i_clk (.clk(clk), .rst_n(rst_n));

    decode_stage i_dut (
        .clk(clk), .rst_n(rst_n), .pc(pc), .inst(inst), .in_delayslot(in_delayslot),
        .ex_result(ex_result), .mem_fwd(mem_fwd), .wb(wb), .stall(stall),
        .branch_flag(branch_flag), .branch_target(branch_target),
        .next_in_delayslot(next_in_delayslot), .ex(ex)
    );

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    function automatic logic [31:0] r_type(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                           logic [4:0] sa, logic [5:0] fn);
        return {OPC_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] i_type(logic [5:0] opc, logic [4:0] rs, logic [4:0] rt,
                                           logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic row_t mk(logic [31:0] w, logic n1r, logic n2r, logic [31:0] imm,
                                op_t op, sel_t sel, logic wd, logic [4:0] dest,
                                logic [2:0] br, logic link);
        row_t r;
        r           = '0;
        r.pc        = 32'h0040_0000 + 32'(rows.size() * 4);
        r.inst      = w;
        r.ex_result = rand_bits(32);
        r.n1r       = n1r;
        r.n2r       = n2r;
        r.imm       = imm;
        r.op        = op;
        r.sel       = sel;
        r.wd        = wd;
        r.dest      = dest;
        r.br        = br;
        r.link      = link;
        return r;
    endfunction

    // operand as the priority rules predict it
    function automatic logic [31:0] pred(logic rd, logic [4:0] a, logic [31:0] imm, row_t r);
        if (!rd) return imm;
        if (pex.wd && pex.dest == a) return r.ex_result;
        if (r.mem.we && r.mem.addr == a) return r.mem.data;
        return shadow[a];
    endfunction

    task automatic chk(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_row(row_t r);
        logic [31:0] n1;
        logic [31:0] n2;
        logic [31:0] tgt;
        logic        flag;
        n1   = pred(r.n1r, r.inst[25:21], r.imm, r);
        n2   = pred(r.n2r, r.inst[20:16], r.imm, r);
        flag = (r.br == 1) || (r.br == 2) || (r.br == 3 && n1 == n2) || (r.br == 4 && n1 != n2);
        tgt  = (r.br == 1) ? {r.pc[31:28] + 4'((r.pc + 4) >> 28) - r.pc[31:28],
                              r.inst[25:0], 2'b00} :
               (r.br == 2) ? n1 : r.pc + 4 + {{14{r.inst[15]}}, r.inst[15:0], 2'b00};
        chk("stall", stall, r.stall);
        if (!r.stall) begin
            chk("branch_flag", branch_flag, flag);
            chk("next_in_delayslot", next_in_delayslot, flag);
            if (flag) chk("branch_target", branch_target, tgt);
        end
        chk("ex.op", ex.op, pex.op);
        chk("ex.sel", ex.sel, pex.sel);
        chk("ex.wd", ex.wd, pex.wd);
        chk("ex.dest", ex.dest, pex.dest);
        chk("ex.in_delayslot", ex.in_delayslot, pex.in_delayslot);
        if (pnums) begin
            chk("ex.num1", ex.num1, pex.num1);
            chk("ex.num2", ex.num2, pex.num2);
            chk("ex.link_address", ex.link_address, pex.link_address);
        end
        pex   = '0;                              // bubble unless loaded below
        pex.op  = OP_NOP;
        pex.sel = SEL_NOP;
        pnums = !r.stall;
        if (!r.stall) begin
            pex.op           = r.op;
            pex.sel          = r.sel;
            pex.num1         = n1;
            pex.num2         = n2;
            pex.wd           = r.wd;
            pex.dest         = r.dest;
            pex.link_address = r.link ? r.pc + 8 : 32'h0;
            pex.in_delayslot = r.ds;
        end
        if (r.wb.we && r.wb.addr != 0) shadow[r.wb.addr] = r.wb.data;  // $zero stays 0
    endtask

    // outputs inactive and ex a bubble around reset
    task automatic check_idle(logic exp_rst_n);
        assert (rst_n === exp_rst_n) else begin
            $display("reset level is %b at a cycle where %b was due", rst_n, exp_rst_n);
            $display("RESULT: FAIL");
            $fatal(1);
        end
        chk("stall", stall, 0);
        chk("branch_flag", branch_flag, 0);
        chk("next_in_delayslot", next_in_delayslot, 0);
        chk("ex.op", ex.op, OP_NOP);
        chk("ex.sel", ex.sel, SEL_NOP);
        chk("ex.wd", ex.wd, 0);
        chk("ex.dest", ex.dest, 0);
        chk("ex.in_delayslot", ex.in_delayslot, 0);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout, the table did not finish within %0d cycles", limit);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

    initial begin
        row_t r;
        pc = '0;
        inst = {OPC_JAL, 26'h0000040};           // a jump waits through reset
        in_delayslot = 1'b0;
        ex_result = '0;
        mem_fwd = '0;
        wb = '0;
        pex = '0;
        pex.op = OP_NOP;
        pex.sel = SEL_NOP;
        pnums = 1'b0;
        for (int k = 0; k < 32; k++) shadow[k] = '0;
        for (int k = 0; k <= 6; k++) begin     // preload r1..r6, then a write to r0
            r = mk(IDLE, 0, 0, 0, OP_NOP, SEL_NOP, 0, 0, 0, 0);
            r.wb = '{1'b1, 5'((k + 1) % 7), rand_bits(32)};
            rows.push_back(r);
        end
        rows.push_back(mk(r_type(1, 2, 7, 0, FN_ADD), 1, 1, 0, OP_ADD, SEL_ARITH, 1, 7, 0, 0));
        rows.push_back(mk(i_type(OPC_ORI, 3, 8, 16'h8001), 1, 0, 32'h0000_8001,
                          OP_OR, SEL_LOGIC, 1, 8, 0, 0));
        rows.push_back(mk(i_type(OPC_ADDI, 4, 9, 16'h8001), 1, 0, 32'hffff_8001,
                          OP_ADDI, SEL_ARITH, 1, 9, 0, 0));
        rows.push_back(mk(i_type(OPC_LUI, 0, 10, 16'h1234), 1, 0, 32'h1234_0000,
                          OP_OR, SEL_LOGIC, 1, 10, 0, 0));
        rows.push_back(mk(r_type(0, 5, 11, 3, FN_SLL), 0, 1, 3, OP_SLL, SEL_SHIFT, 1, 11, 0, 0));
        rows.push_back(mk(r_type(1, 6, 12, 0, FN_SRAV), 1, 1, 0, OP_SRA, SEL_SHIFT, 1, 12, 0, 0));
        rows.push_back(mk(i_type(OPC_SLTIU, 2, 13, 16'hffff), 1, 0, 32'hffff_ffff,
                          OP_SLTU, SEL_ARITH, 1, 13, 0, 0));
        rows.push_back(mk(r_type(0, 0, 14, 0, FN_OR), 1, 1, 0, OP_OR, SEL_LOGIC, 1, 14, 0, 0));
        rows.push_back(mk(r_type(1, 2, 15, 0, FN_ADD), 1, 1, 0, OP_ADD, SEL_ARITH, 1, 15, 0, 0));
        r = mk(r_type(15, 3, 16, 0, FN_SUB), 1, 1, 0, OP_SUB, SEL_ARITH, 1, 16, 0, 0);
        r.mem = '{1'b1, 5'd15, rand_bits(32)};   // execute match wins
        rows.push_back(r);
        r = mk(r_type(3, 15, 17, 0, FN_AND), 1, 1, 0, OP_AND, SEL_LOGIC, 1, 17, 0, 0);
        r.mem = '{1'b1, 5'd15, rand_bits(32)};
        rows.push_back(r);
        rows.push_back(mk(i_type(OPC_LW, 1, 18, 16'h0004), 1, 0, 32'h4,
                          OP_LW, SEL_LOAD_STORE, 1, 18, 0, 0));
        r = mk(r_type(18, 2, 19, 0, FN_ADDU), 1, 1, 0, OP_ADDU, SEL_ARITH, 1, 19, 0, 0);
        r.stall = 1'b1;
        r.ds = 1'b1;                             // the bubble drops the slot flag
        rows.push_back(r);
        r.stall = 1'b0;                          // held word takes the load data from mem
        r.ex_result = rand_bits(32);
        r.mem = '{1'b1, 5'd18, rand_bits(32)};
        rows.push_back(r);
        rows.push_back(mk(i_type(OPC_SW, 1, 2, 16'h0008), 1, 1, 32'h8,
                          OP_SW, SEL_LOAD_STORE, 0, 0, 0, 0));
        rows.push_back(mk(i_type(OPC_BEQ, 1, 1, 16'h0010), 1, 1, 0,
                          OP_BEQ, SEL_JUMP_BRANCH, 0, 0, 3, 0));
        rows.push_back(mk(i_type(OPC_BEQ, 1, 2, 16'hfffc), 1, 1, 0,
                          OP_BEQ, SEL_JUMP_BRANCH, 0, 31, 3, 0));
        rows.push_back(mk(i_type(OPC_BNE, 1, 2, 16'h0020), 1, 1, 0,
                          OP_BNE, SEL_JUMP_BRANCH, 0, 0, 4, 0));
        r = mk(i_type(OPC_BNE, 3, 3, 16'h0020), 1, 1, 0, OP_BNE, SEL_JUMP_BRANCH, 0, 0, 4, 0);
        r.ds = 1'b1;
        rows.push_back(r);
        r = mk({OPC_J, 26'h0120456}, 0, 0, 0, OP_J, SEL_JUMP_BRANCH, 0, 0, 1, 0);
        r.pc = 32'ha000_0000;
        rows.push_back(r);
        rows.push_back(mk({OPC_JAL, 26'h0000100}, 0, 0, 0, OP_JAL, SEL_JUMP_BRANCH, 1, 31, 1, 1));
        r = mk(r_type(4, 0, 0, 0, FN_JR), 1, 0, 0, OP_JR, SEL_JUMP_BRANCH, 0, 0, 2, 0);
        r.ds = 1'b1;
        rows.push_back(r);
        rows.push_back(mk(r_type(5, 0, 31, 0, FN_JALR), 1, 0, 0,
                          OP_JALR, SEL_JUMP_BRANCH, 1, 31, 2, 1));
        rows.push_back(mk(r_type(31, 0, 0, 0, FN_JR), 1, 0, 0,
                          OP_JR, SEL_JUMP_BRANCH, 0, 0, 2, 0));  // target from ex_result
        rows.push_back(mk(IDLE, 0, 0, 0, OP_NOP, SEL_NOP, 0, 0, 0, 0));
        limit = 16 + rows.size() + 20;

        @(posedge clk);                          // first edge loads the reset bubble
        repeat (15) begin
            @(negedge clk);
            check_idle(1'b0);
        end
        @(posedge clk);
        inst <= IDLE;                            // fetch drops the jump as reset ends
        @(negedge clk);
        check_idle(1'b1);                        // first cycle out of reset
        foreach (rows[i]) begin
            @(posedge clk);
            pc           <= rows[i].pc;
            inst         <= rows[i].inst;
            in_delayslot <= rows[i].ds;
            ex_result    <= rows[i].ex_result;
            mem_fwd      <= rows[i].mem;
            wb           <= rows[i].wb;
            @(negedge clk);
            check_row(rows[i]);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                  // 100 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;                           // released on the 16th edge
    end

endmodule

`default_nettype wire
